/* compile.f */
+incdir+logic
logic/lrsc_pkg.sv
logic/lrsc_res_table.sv
logic/lrsc_read_ctrl.sv
logic/lrsc_write_ctrl.sv
logic/lrsc_adapter.sv
test/lrsc_mem_slave.sv
test/lrsc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f compile.f --top-module lrsc_tb -o lrsc_sim \
    || { echo "Verilator build error"; exit 1; }
./obj_dir/lrsc_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
! grep -q "test failed" sim.log && grep -q "test passed" sim.log

/* test/lrsc_tb.sv */
// **************************************************************************
// Testbench of the LR/SC adapter with a behavioural memory slave behind it
// Transactions run one at a time and a model tracks memory and reservations
// Memory words are indexed by the low 8 address bits
// **************************************************************************

`include "lrsc_config.svh"

module lrsc_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 100;
    localparam int NUM_IDS = 1 << `LRSC_ID_W;

    logic                   clk_i;
    logic                   rst_ni;
    lrsc_pkg::ar_chan_t     slv_ar_i, mst_ar_o;
    lrsc_pkg::aw_chan_t     slv_aw_i, mst_aw_o;
    lrsc_pkg::w_chan_t      slv_w_i, mst_w_o;
    lrsc_pkg::r_chan_t      slv_r_o, mst_r_i;
    lrsc_pkg::b_chan_t      slv_b_o, mst_b_i;
    logic                   slv_ar_valid_i, slv_ar_ready_o, mst_ar_valid_o, mst_ar_ready_i;
    logic                   slv_aw_valid_i, slv_aw_ready_o, mst_aw_valid_o, mst_aw_ready_i;
    logic                   slv_w_valid_i, slv_w_ready_o, mst_w_valid_o, mst_w_ready_i;
    logic                   slv_r_valid_o, slv_r_ready_i, mst_r_valid_i, mst_r_ready_o;
    logic                   slv_b_valid_o, slv_b_ready_i, mst_b_valid_i, mst_b_ready_o;

    // Reference model
    lrsc_pkg::data_t        shadow [256];
    logic [NUM_IDS-1:0]     res_valid;
    lrsc_pkg::addr_t        res_addr [NUM_IDS];
    logic [15:0]            lfsr_q;

    lrsc_adapter dut_i (.*);

    lrsc_mem_slave mem_i (
        .clk_i      (clk_i),
        .ar_i       (mst_ar_o),
        .ar_valid_i (mst_ar_valid_o),
        .ar_ready_o (mst_ar_ready_i),
        .r_o        (mst_r_i),
        .r_valid_o  (mst_r_valid_i),
        .r_ready_i  (mst_r_ready_o),
        .aw_i       (mst_aw_o),
        .aw_valid_i (mst_aw_valid_o),
        .aw_ready_o (mst_aw_ready_i),
        .w_i        (mst_w_o),
        .w_valid_i  (mst_w_valid_o),
        .w_ready_o  (mst_w_ready_i),
        .b_o        (mst_b_i),
        .b_valid_o  (mst_b_valid_i),
        .b_ready_i  (mst_b_ready_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // Fibonacci LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // Power-up content of the memory slave
    function automatic lrsc_pkg::data_t fill_word(input int i);
        return {i[7:0], ~i[7:0], i[7:0] ^ 8'h5A, 8'hC3};
    endfunction

    function automatic logic in_window(input lrsc_pkg::addr_t a);
        return (a >= `LRSC_EXCL_BEGIN) && (a <= `LRSC_EXCL_END);
    endfunction

    task automatic report_failure();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic handshake_timeout(input string what);
        $display("Timeout: the %s handshake never completed", what);
        report_failure();
    endtask

    task automatic read_checked(input string name, input lrsc_pkg::addr_t addr,
                                input lrsc_pkg::id_t id, input logic lock, input logic bp);
        lrsc_pkg::data_t    exp_data;
        lrsc_pkg::resp_e    exp_resp;
        lrsc_pkg::r_chan_t  got;
        logic               done;
        int                 n;
        exp_data = shadow[addr[7:0]];
        exp_resp = (lock && in_window(addr)) ? lrsc_pkg::EXOKAY : lrsc_pkg::OKAY;
        if (lock && in_window(addr)) begin
            res_valid[id] = 1'b1;
            res_addr[id]  = addr;
        end
        @(negedge clk_i);
        slv_ar_i.addr  = addr;
        slv_ar_i.id    = id;
        slv_ar_i.lock  = lock;
        slv_ar_valid_i = 1'b1;
        done = 1'b0;
        n = 0;
        while (!done) begin
            @(posedge clk_i);
            done = slv_ar_valid_i && slv_ar_ready_o;
            @(negedge clk_i);
            slv_ar_valid_i = !done;
            n++;
            if (!done && n > TIMEOUT) handshake_timeout("AR");
        end
        done = 1'b0;
        n = 0;
        while (!done) begin
            slv_r_ready_i = bp ? 1'(rand_bits(1)) : 1'b1;
            @(posedge clk_i);
            done = slv_r_valid_o && slv_r_ready_i;
            got = slv_r_o;
            @(negedge clk_i);
            n++;
            if (!done && n > TIMEOUT) handshake_timeout("R");
        end
        slv_r_ready_i = 1'b0;
        check_value({name, " data"}, 64'(exp_data), 64'(got.data));
        check_value({name, " resp"}, 64'(exp_resp), 64'(got.resp));
        check_value({name, " id"}, 64'(id), 64'(got.id));
    endtask

    task automatic write_checked(input string name, input lrsc_pkg::addr_t addr,
                                 input lrsc_pkg::id_t id, input logic lock,
                                 input lrsc_pkg::data_t data, input lrsc_pkg::strb_t strb,
                                 input logic bp);
        lrsc_pkg::b_chan_t  got;
        logic               hit, aw_done, w_done, done;
        int                 n;
        // A store-conditional without its reservation leaves everything as is
        hit = res_valid[id] && (res_addr[id] == addr);
        if (!(lock && in_window(addr) && !hit)) begin
            for (int i = 0; i < $bits(strb); i++) begin
                if (strb[i]) shadow[addr[7:0]][8*i +: 8] = data[8*i +: 8];
            end
            if (in_window(addr)) begin
                for (int i = 0; i < NUM_IDS; i++) begin
                    if (res_addr[i] == addr) res_valid[i] = 1'b0;
                end
            end
        end
        @(negedge clk_i);
        slv_aw_i.addr  = addr;
        slv_aw_i.id    = id;
        slv_aw_i.lock  = lock;
        slv_w_i.data   = data;
        slv_w_i.strb   = strb;
        slv_aw_valid_i = 1'b1;
        slv_w_valid_i  = 1'b1;
        aw_done = 1'b0;
        w_done = 1'b0;
        n = 0;
        while (!(aw_done && w_done)) begin
            @(posedge clk_i);
            aw_done = aw_done || (slv_aw_valid_i && slv_aw_ready_o);
            w_done = w_done || (slv_w_valid_i && slv_w_ready_o);
            @(negedge clk_i);
            slv_aw_valid_i = !aw_done;
            slv_w_valid_i = !w_done;
            n++;
            if (!(aw_done && w_done) && n > TIMEOUT) handshake_timeout("AW/W");
        end
        done = 1'b0;
        n = 0;
        while (!done) begin
            slv_b_ready_i = bp ? 1'(rand_bits(1)) : 1'b1;
            @(posedge clk_i);
            done = slv_b_valid_o && slv_b_ready_i;
            got = slv_b_o;
            @(negedge clk_i);
            n++;
            if (!done && n > TIMEOUT) handshake_timeout("B");
        end
        slv_b_ready_i = 1'b0;
        check_value({name, " resp"}, 64'(lrsc_pkg::OKAY), 64'(got.resp));
        check_value({name, " id"}, 64'(id), 64'(got.id));
    endtask

    initial begin
        lrsc_pkg::addr_t    addr;
        lrsc_pkg::id_t      id;
        logic               lock;
        lfsr_q = 16'd83;
        rst_ni = 1'b0;
        slv_ar_i = '0;
        slv_aw_i = '0;
        slv_w_i = '0;
        {slv_ar_valid_i, slv_aw_valid_i, slv_w_valid_i} = '0;
        {slv_r_ready_i, slv_b_ready_i} = '0;
        res_valid = '0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = fill_word(i);
        end
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        write_checked("plain write in window", 16'h0120, 2'd0, 1'b0, 32'h1111_2222, 4'hF, 1'b0);
        read_checked("plain read in window", 16'h0120, 2'd0, 1'b0, 1'b0);
        write_checked("plain write outside", 16'h0040, 2'd1, 1'b0, 32'h3333_4444, 4'hF, 1'b0);
        read_checked("plain read outside", 16'h0040, 2'd1, 1'b0, 1'b0);

        read_checked("exclusive read", 16'h0130, 2'd1, 1'b1, 1'b0);
        write_checked("reserved exclusive write", 16'h0130, 2'd1, 1'b1, 32'hCAFE_0001, 4'hF, 1'b0);
        read_checked("read after store", 16'h0130, 2'd1, 1'b0, 1'b0);

        write_checked("unreserved exclusive write", 16'h0140, 2'd2, 1'b1, 32'hDEAD_0002, 4'hF, 1'b0);
        read_checked("read after failed store", 16'h0140, 2'd2, 1'b0, 1'b0);

        // Reservation of ID 3 is lost to a plain write of ID 0
        read_checked("reserving read", 16'h0150, 2'd3, 1'b1, 1'b0);
        write_checked("foreign write", 16'h0150, 2'd0, 1'b0, 32'h0BAD_F00D, 4'hF, 1'b0);
        write_checked("store after loss", 16'h0150, 2'd3, 1'b1, 32'hFFFF_0003, 4'hF, 1'b0);
        read_checked("read keeps foreign data", 16'h0150, 2'd3, 1'b0, 1'b0);

        read_checked("exclusive read outside", 16'h0060, 2'd1, 1'b1, 1'b0);
        write_checked("exclusive write outside", 16'h0070, 2'd1, 1'b1, 32'h7777_0005, 4'hF, 1'b0);
        read_checked("read after outside store", 16'h0070, 2'd1, 1'b0, 1'b0);

        // Addresses 0x00F8 to 0x0107 straddle the window start
        for (int k = 0; k < 200; k++) begin
            addr = 16'h00F8 + 16'(rand_bits(4));
            id = 2'(rand_bits(2));
            lock = 1'(rand_bits(1));
            if (rand_bits(1) == 32'd1) begin
                read_checked($sformatf("random op %0d read", k), addr, id, lock, 1'b1);
            end else begin
                // Often aim a store-conditional at its own reservation
                if (lock && res_valid[id] && rand_bits(1) == 32'd1) addr = res_addr[id];
                write_checked($sformatf("random op %0d write", k), addr, id, lock,
                              rand_bits(32), 4'(rand_bits(4)), 1'b1);
            end
        end

        $display("test passed");
        $finish;
    end

endmodule

/* test/lrsc_mem_slave.sv */
// **************************************************************************
// Behavioural memory slave, 256 words indexed by the low 8 address bits
// One read and one write in flight and every response is OKAY
// Ready and valid delays come from an LFSR seeded with 83
// Power-up word i holds {i, ~i, i ^ 8'h5A, 8'hC3}
// **************************************************************************

module lrsc_mem_slave (
    input  logic                clk_i,
    input  lrsc_pkg::ar_chan_t  ar_i,
    input  logic                ar_valid_i,
    output logic                ar_ready_o,
    output lrsc_pkg::r_chan_t   r_o,
    output logic                r_valid_o,
    input  logic                r_ready_i,
    input  lrsc_pkg::aw_chan_t  aw_i,
    input  logic                aw_valid_i,
    output logic                aw_ready_o,
    input  lrsc_pkg::w_chan_t   w_i,
    input  logic                w_valid_i,
    output logic                w_ready_o,
    output lrsc_pkg::b_chan_t   b_o,
    output logic                b_valid_o,
    input  logic                b_ready_i
);

    timeunit 1ns;
    timeprecision 1ps;

    lrsc_pkg::data_t    mem_q [256];
    lrsc_pkg::ar_chan_t ar_q;
    lrsc_pkg::aw_chan_t aw_q;
    lrsc_pkg::w_chan_t  w_q;
    logic [15:0]        lfsr_q;
    logic               ar_fire, r_fire, aw_fire, w_fire, b_fire;
    logic               rd_busy, have_aw, have_w;

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic random_bit();
        lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
        return lfsr_q[0];
    endfunction

    initial begin
        lfsr_q = 16'd83;
        {rd_busy, have_aw, have_w} = '0;
        {ar_ready_o, r_valid_o, aw_ready_o, w_ready_o, b_valid_o} = '0;
        r_o = '0;
        b_o = '0;
        for (int i = 0; i < 256; i++) begin
            mem_q[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5A, 8'hC3};
        end
    end

    // Transfers are taken on the rising edge and acted on at the falling edge
    always @(posedge clk_i) begin
        ar_fire <= ar_valid_i && ar_ready_o;
        r_fire  <= r_valid_o && r_ready_i;
        aw_fire <= aw_valid_i && aw_ready_o;
        w_fire  <= w_valid_i && w_ready_o;
        b_fire  <= b_valid_o && b_ready_i;
        if (ar_valid_i && ar_ready_o) begin
            ar_q <= ar_i;
        end
        if (aw_valid_i && aw_ready_o) begin
            aw_q <= aw_i;
        end
        if (w_valid_i && w_ready_o) begin
            w_q <= w_i;
        end
    end

    always @(negedge clk_i) begin
        if (ar_fire) begin
            ar_ready_o = 1'b0;
            rd_busy    = 1'b1;
            r_o.data   = mem_q[ar_q.addr[7:0]];
            r_o.resp   = lrsc_pkg::OKAY;
            r_o.id     = ar_q.id;
        end
        if (r_fire) begin
            r_valid_o = 1'b0;
            rd_busy   = 1'b0;
        end
        if (!rd_busy) begin
            ar_ready_o = random_bit();
        end else if (!r_valid_o) begin
            r_valid_o = random_bit();
        end

        if (aw_fire) begin
            aw_ready_o = 1'b0;
            have_aw    = 1'b1;
        end
        if (w_fire) begin
            w_ready_o = 1'b0;
            have_w    = 1'b1;
        end
        // Only enabled bytes change
        if ((aw_fire || w_fire) && have_aw && have_w) begin
            for (int j = 0; j < 4; j++) begin
                if (w_q.strb[j]) begin
                    mem_q[aw_q.addr[7:0]][8*j +: 8] = w_q.data[8*j +: 8];
                end
            end
            b_o.resp = lrsc_pkg::OKAY;
            b_o.id   = aw_q.id;
        end
        if (b_fire) begin
            b_valid_o = 1'b0;
            have_aw   = 1'b0;
            have_w    = 1'b0;
        end
        if (have_aw && have_w) begin
            if (!b_valid_o) begin
                b_valid_o = random_bit();
            end
        end else begin
            if (!have_aw) begin
                aw_ready_o = random_bit();
            end
            if (!have_w) begin
                w_ready_o = random_bit();
            end
        end
    end

endmodule

/* logic/lrsc_adapter.sv */
// **************************************************************************
// LR/SC adapter between an upstream master and a plain memory slave
// Exclusive accesses are honoured only inside the configured window
// At most one read and one write are outstanding; all beats are single
// **************************************************************************

module lrsc_adapter (
    input  logic                clk_i,
    input  logic                rst_ni,

    // Upstream side, driven by the bus master
    input  lrsc_pkg::ar_chan_t  slv_ar_i,
    input  logic                slv_ar_valid_i,
    output logic                slv_ar_ready_o,
    input  lrsc_pkg::aw_chan_t  slv_aw_i,
    input  logic                slv_aw_valid_i,
    output logic                slv_aw_ready_o,
    input  lrsc_pkg::w_chan_t   slv_w_i,
    input  logic                slv_w_valid_i,
    output logic                slv_w_ready_o,
    output lrsc_pkg::r_chan_t   slv_r_o,
    output logic                slv_r_valid_o,
    input  logic                slv_r_ready_i,
    output lrsc_pkg::b_chan_t   slv_b_o,
    output logic                slv_b_valid_o,
    input  logic                slv_b_ready_i,

    // Downstream side, towards the memory slave
    output lrsc_pkg::ar_chan_t  mst_ar_o,
    output logic                mst_ar_valid_o,
    input  logic                mst_ar_ready_i,
    output lrsc_pkg::aw_chan_t  mst_aw_o,
    output logic                mst_aw_valid_o,
    input  logic                mst_aw_ready_i,
    output lrsc_pkg::w_chan_t   mst_w_o,
    output logic                mst_w_valid_o,
    input  logic                mst_w_ready_i,
    input  lrsc_pkg::r_chan_t   mst_r_i,
    input  logic                mst_r_valid_i,
    output logic                mst_r_ready_o,
    input  lrsc_pkg::b_chan_t   mst_b_i,
    input  logic                mst_b_valid_i,
    output logic                mst_b_ready_o
);

    logic               set_valid, chk_hit, clr_valid;
    lrsc_pkg::addr_t    set_addr, chk_addr, clr_addr;
    lrsc_pkg::id_t      set_id, chk_id;

    // Channel ports share names with the top, so they bind implicitly
    lrsc_read_ctrl read_ctrl_i (
        .*,
        .set_valid_o (set_valid),
        .set_addr_o  (set_addr),
        .set_id_o    (set_id)
    );

    lrsc_write_ctrl write_ctrl_i (
        .*,
        .chk_addr_o  (chk_addr),
        .chk_id_o    (chk_id),
        .chk_hit_i   (chk_hit),
        .clr_valid_o (clr_valid),
        .clr_addr_o  (clr_addr)
    );

    lrsc_res_table res_table_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .set_valid_i (set_valid),
        .set_addr_i  (set_addr),
        .set_id_i    (set_id),
        .chk_addr_i  (chk_addr),
        .chk_id_i    (chk_id),
        .chk_hit_o   (chk_hit),
        .clr_valid_i (clr_valid),
        .clr_addr_i  (clr_addr)
    );

endmodule

/* logic/lrsc_write_ctrl.sv */
// **************************************************************************
// AW/W/B controller, one write outstanding at a time
// Exclusive writes in the window need a matching reservation, else the
// data beat is swallowed and OKAY is returned without touching memory
// Every forwarded in-window write clears reservations on its address
// **************************************************************************

`include "lrsc_config.svh"

module lrsc_write_ctrl (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  lrsc_pkg::aw_chan_t  slv_aw_i,
    input  logic                slv_aw_valid_i,
    output logic                slv_aw_ready_o,
    input  lrsc_pkg::w_chan_t   slv_w_i,
    input  logic                slv_w_valid_i,
    output logic                slv_w_ready_o,
    output lrsc_pkg::b_chan_t   slv_b_o,
    output logic                slv_b_valid_o,
    input  logic                slv_b_ready_i,

    output lrsc_pkg::aw_chan_t  mst_aw_o,
    output logic                mst_aw_valid_o,
    input  logic                mst_aw_ready_i,
    output lrsc_pkg::w_chan_t   mst_w_o,
    output logic                mst_w_valid_o,
    input  logic                mst_w_ready_i,
    input  lrsc_pkg::b_chan_t   mst_b_i,
    input  logic                mst_b_valid_i,
    output logic                mst_b_ready_o,

    output lrsc_pkg::addr_t     chk_addr_o,
    output lrsc_pkg::id_t       chk_id_o,
    input  logic                chk_hit_i,
    output logic                clr_valid_o,
    output lrsc_pkg::addr_t     clr_addr_o
);

    lrsc_pkg::w_state_e w_state_q, w_state_d;
    lrsc_pkg::addr_t    w_addr_q;
    lrsc_pkg::id_t      w_id_q;
    logic               aw_in_win;

    assign aw_in_win = (slv_aw_i.addr >= `LRSC_EXCL_BEGIN)
                    && (slv_aw_i.addr <= `LRSC_EXCL_END);

    assign mst_aw_o = slv_aw_i;
    assign mst_w_o  = slv_w_i;

    // Lookup is driven straight from the pending AW
    assign chk_addr_o = slv_aw_i.addr;
    assign chk_id_o   = slv_aw_i.id;

    assign clr_addr_o  = w_addr_q;
    assign clr_valid_o = (w_state_q == lrsc_pkg::W_FORWARD) && slv_w_valid_i && mst_w_ready_i;

    always_comb begin
        mst_aw_valid_o = 1'b0;
        slv_aw_ready_o = 1'b0;
        mst_w_valid_o  = 1'b0;
        slv_w_ready_o  = 1'b0;
        mst_b_ready_o  = 1'b0;
        slv_b_valid_o  = 1'b0;
        slv_b_o        = mst_b_i;
        w_state_d      = w_state_q;

        case (w_state_q)
            lrsc_pkg::W_IDLE: begin
                if (slv_aw_valid_i) begin
                    if (aw_in_win && slv_aw_i.lock && !chk_hit_i) begin
                        // Failed store-conditional, nothing goes downstream
                        slv_aw_ready_o = 1'b1;
                        w_state_d = lrsc_pkg::W_DROP;
                    end else begin
                        mst_aw_valid_o = 1'b1;
                        slv_aw_ready_o = mst_aw_ready_i;
                        if (mst_aw_ready_i) begin
                            w_state_d = aw_in_win ? lrsc_pkg::W_FORWARD : lrsc_pkg::W_BYPASS;
                        end
                    end
                end
            end
            lrsc_pkg::W_FORWARD, lrsc_pkg::W_BYPASS: begin
                mst_w_valid_o = slv_w_valid_i;
                slv_w_ready_o = mst_w_ready_i;
                if (slv_w_valid_i && mst_w_ready_i) begin
                    w_state_d = lrsc_pkg::B_FORWARD;
                end
            end
            lrsc_pkg::W_DROP: begin
                slv_w_ready_o = 1'b1;
                if (slv_w_valid_i) begin
                    w_state_d = lrsc_pkg::B_INJECT;
                end
            end
            lrsc_pkg::B_FORWARD: begin
                mst_b_ready_o = slv_b_ready_i;
                slv_b_valid_o = mst_b_valid_i;
                if (mst_b_valid_i && slv_b_ready_i) begin
                    w_state_d = lrsc_pkg::W_IDLE;
                end
            end
            lrsc_pkg::B_INJECT: begin
                slv_b_valid_o = 1'b1;
                slv_b_o.resp  = lrsc_pkg::OKAY;
                slv_b_o.id    = w_id_q;
                if (slv_b_ready_i) begin
                    w_state_d = lrsc_pkg::W_IDLE;
                end
            end
            default: w_state_d = lrsc_pkg::W_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            w_state_q <= lrsc_pkg::W_IDLE;
        end else begin
            w_state_q <= w_state_d;
        end
    end

    // Address and ID of the accepted AW
    always_ff @(posedge clk_i) begin
        if (slv_aw_valid_i && slv_aw_ready_o) begin
            w_addr_q <= slv_aw_i.addr;
            w_id_q   <= slv_aw_i.id;
        end
    end

endmodule

/* logic/lrsc_read_ctrl.sv */
// **************************************************************************
// AR/R controller, one read outstanding at a time
// An in-window exclusive AR reserves its address for its ID on acceptance
// Non-error responses of such a read are upgraded to EXOKAY
// **************************************************************************

`include "lrsc_config.svh"

module lrsc_read_ctrl (
    input  logic                clk_i,
    input  logic                rst_ni,

    input  lrsc_pkg::ar_chan_t  slv_ar_i,
    input  logic                slv_ar_valid_i,
    output logic                slv_ar_ready_o,
    output lrsc_pkg::r_chan_t   slv_r_o,
    output logic                slv_r_valid_o,
    input  logic                slv_r_ready_i,

    output lrsc_pkg::ar_chan_t  mst_ar_o,
    output logic                mst_ar_valid_o,
    input  logic                mst_ar_ready_i,
    input  lrsc_pkg::r_chan_t   mst_r_i,
    input  logic                mst_r_valid_i,
    output logic                mst_r_ready_o,

    output logic                set_valid_o,
    output lrsc_pkg::addr_t     set_addr_o,
    output lrsc_pkg::id_t       set_id_o
);

    lrsc_pkg::r_state_e r_state_q, r_state_d;
    logic               r_excl_q, r_excl_d;
    logic               ar_excl;
    logic               ar_accept;

    assign ar_excl = slv_ar_i.lock
                  && (slv_ar_i.addr >= `LRSC_EXCL_BEGIN)
                  && (slv_ar_i.addr <= `LRSC_EXCL_END);
    assign ar_accept = slv_ar_valid_i && slv_ar_ready_o;

    // Request goes downstream unchanged
    assign mst_ar_o = slv_ar_i;

    assign set_valid_o = ar_accept && ar_excl;
    assign set_addr_o  = slv_ar_i.addr;
    assign set_id_o    = slv_ar_i.id;

    assign r_excl_d = ar_accept ? ar_excl : r_excl_q;

    always_comb begin
        mst_ar_valid_o = 1'b0;
        slv_ar_ready_o = 1'b0;
        mst_r_ready_o  = 1'b0;
        slv_r_valid_o  = 1'b0;
        r_state_d      = r_state_q;

        case (r_state_q)
            lrsc_pkg::R_IDLE: begin
                if (slv_ar_valid_i) begin
                    mst_ar_valid_o = 1'b1;
                    slv_ar_ready_o = mst_ar_ready_i;
                    r_state_d = mst_ar_ready_i ? lrsc_pkg::R_WAIT_R : lrsc_pkg::R_WAIT_AR;
                end
            end
            lrsc_pkg::R_WAIT_AR: begin
                mst_ar_valid_o = slv_ar_valid_i;
                slv_ar_ready_o = mst_ar_ready_i;
                if (slv_ar_valid_i && mst_ar_ready_i) begin
                    r_state_d = lrsc_pkg::R_WAIT_R;
                end
            end
            lrsc_pkg::R_WAIT_R: begin
                mst_r_ready_o = slv_r_ready_i;
                slv_r_valid_o = mst_r_valid_i;
                if (mst_r_valid_i && slv_r_ready_i) begin
                    r_state_d = lrsc_pkg::R_IDLE;
                end
            end
            default: r_state_d = lrsc_pkg::R_IDLE;
        endcase
    end

    // Errors keep their code, everything else reflects the exclusive flag
    always_comb begin
        slv_r_o = mst_r_i;
        if (!mst_r_i.resp[1]) begin
            slv_r_o.resp = r_excl_q ? lrsc_pkg::EXOKAY : lrsc_pkg::OKAY;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            r_state_q <= lrsc_pkg::R_IDLE;
            r_excl_q  <= 1'b0;
        end else begin
            r_state_q <= r_state_d;
            r_excl_q  <= r_excl_d;
        end
    end

endmodule

/* logic/lrsc_res_table.sv */
// **************************************************************************
// Reservation table with one slot per transaction ID
// Set, check and clear are always accepted; updates show the next cycle
// A set wins over a clear of the same slot in the same cycle
// **************************************************************************

`include "lrsc_config.svh"

module lrsc_res_table (
    input  logic                clk_i,
    input  logic                rst_ni,

    // Reservation from an exclusive read
    input  logic                set_valid_i,
    input  lrsc_pkg::addr_t     set_addr_i,
    input  lrsc_pkg::id_t       set_id_i,

    // Lookup for an exclusive write
    input  lrsc_pkg::addr_t     chk_addr_i,
    input  lrsc_pkg::id_t       chk_id_i,
    output logic                chk_hit_o,

    // Invalidate every slot on an address
    input  logic                clr_valid_i,
    input  lrsc_pkg::addr_t     clr_addr_i
);

    localparam int unsigned NUM_SLOTS = 1 << `LRSC_ID_W;

    logic [NUM_SLOTS-1:0]   slot_valid_q;
    logic [NUM_SLOTS-1:0]   slot_valid_d;
    lrsc_pkg::addr_t        slot_addr_q [NUM_SLOTS];

    always_comb begin
        slot_valid_d = slot_valid_q;
        for (int unsigned i = 0; i < NUM_SLOTS; i++) begin
            if (clr_valid_i && slot_addr_q[i] == clr_addr_i) begin
                slot_valid_d[i] = 1'b0;
            end
        end
        // Applied last so it overrides a clear on the same slot
        if (set_valid_i) begin
            slot_valid_d[set_id_i] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            slot_valid_q <= '0;
        end else begin
            slot_valid_q <= slot_valid_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (set_valid_i) begin
            slot_addr_q[set_id_i] <= set_addr_i;
        end
    end

    // Answered from registered state only
    assign chk_hit_o = slot_valid_q[chk_id_i] && (slot_addr_q[chk_id_i] == chk_addr_i);

endmodule

/* logic/lrsc_pkg.sv */
// **************************************************************************
// Channel payload types and FSM encodings of the LR/SC adapter
// All beats are single, so there are no burst or last fields
// **************************************************************************

`include "lrsc_config.svh"

package lrsc_pkg;

    typedef logic [`LRSC_ADDR_W-1:0] addr_t;
    typedef logic [`LRSC_DATA_W-1:0] data_t;
    typedef logic [`LRSC_ID_W-1:0] id_t;
    typedef logic [`LRSC_DATA_W/8-1:0] strb_t;

    // Top bit set marks an error response
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    typedef struct packed {
        addr_t addr;
        id_t   id;
        logic  lock;
    } ar_chan_t;

    typedef struct packed {
        addr_t addr;
        id_t   id;
        logic  lock;
    } aw_chan_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
    } w_chan_t;

    typedef struct packed {
        data_t data;
        resp_e resp;
        id_t   id;
    } r_chan_t;

    typedef struct packed {
        resp_e resp;
        id_t   id;
    } b_chan_t;

    typedef enum logic [1:0] {R_IDLE, R_WAIT_AR, R_WAIT_R} r_state_e;

    typedef enum logic [2:0] {
        W_IDLE, W_FORWARD, W_BYPASS, W_DROP, B_FORWARD, B_INJECT
    } w_state_e;

endpackage

/* logic/lrsc_config.svh */
// **************************************************************************
// Bus widths and the exclusive address window of the LR/SC adapter
// The window bounds are inclusive and must lie inside the address range
// The ID width sets the number of reservation slots (one per ID)
// **************************************************************************

`ifndef LRSC_CONFIG_SVH
`define LRSC_CONFIG_SVH

`define LRSC_ADDR_W 16
`define LRSC_DATA_W 32
`define LRSC_ID_W 2

// Exclusive window, both ends inclusive
`define LRSC_EXCL_BEGIN 16'h0100
`define LRSC_EXCL_END 16'h01FF

`endif
